//--- Makefile
SRCS = vlog.f source/rbx_consts.svh $(wildcard source/*.sv) $(wildcard dv/*.sv)

obj_dir/Vrbx_tb: $(SRCS)
	verilator --binary --timing --assert --top-module rbx_tb -f vlog.f

run: obj_dir/Vrbx_tb
	obj_dir/Vrbx_tb | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- dv/rbx_assert.sv
`timescale 1ns/10ps
`include "rbx_consts.svh"

module rbx_assert (
    input logic                    clk,
    input logic                    arst_n,
    input rbx_pkg::rb_write_t      wr,
    input logic [`RBX_RADDR_W-1:0] rd_addr1,
    input logic [`RBX_RADDR_W-1:0] rd_addr2,
    input logic [`RBX_XLEN-1:0]    rd_value1,
    input logic [`RBX_XLEN-1:0]    rd_value2
);
    // x0 reads zero on both ports
    x0_reads_zero_1: assert property (@(posedge clk) disable iff (!arst_n)
        rd_addr1 == '0 |-> rd_value1 == '0)
        else $error("x0 read on port 1 was not zero");

    x0_reads_zero_2: assert property (@(posedge clk) disable iff (!arst_n)
        rd_addr2 == '0 |-> rd_value2 == '0)
        else $error("x0 read on port 2 was not zero");

    // write to x0 leaves the port 1 value alone while its address holds
    x0_write_ignored: assert property (@(posedge clk) disable iff (!arst_n)
        (wr.en && wr.addr == '0) |=>
            (rd_addr1 != $past(rd_addr1) || rd_value1 == $past(rd_value1)))
        else $error("write to x0 changed a read value");

    // no strobe, no change
    disabled_write_holds: assert property (@(posedge clk) disable iff (!arst_n)
        !wr.en |=>
            (rd_addr2 != $past(rd_addr2) || rd_value2 == $past(rd_value2)))
        else $error("register changed without a write strobe");

endmodule

bind register_bank rbx_assert u_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr        (wr),
    .rd_addr1  (rd_addr1),
    .rd_addr2  (rd_addr2),
    .rd_value1 (rd_value1),
    .rd_value2 (rd_value2)
);

//--- dv/rbx_tb.sv
`timescale 1ns/10ps
`include "rbx_consts.svh"

module rbx_tb;

    localparam int BUSY_TIMEOUT = 20 * `RBX_CLKS_PER_BIT;
    localparam int DONE_TIMEOUT = (`RBX_SCRIPT_DEPTH + 4) * `RBX_STEP_DIV * 2;

    logic                    clk;
    logic                    arst_n;
    logic                    uart_line;
    logic [`RBX_RADDR_W-1:0] rd_addr1;
    logic [`RBX_RADDR_W-1:0] rd_addr2;
    logic [`RBX_XLEN-1:0]    rd_value1;
    logic [`RBX_XLEN-1:0]    rd_value2;
    logic [5:0]              led;

    // reference register model
    logic [`RBX_XLEN-1:0] ref_regs [`RBX_NREGS];

    int check_count;
    int error_count;
    int timeout_count;

    rbx_top DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .uart_rx   (uart_line),
        .rd_addr1  (rd_addr1),
        .rd_addr2  (rd_addr2),
        .rd_value1 (rd_value1),
        .rd_value2 (rd_value2),
        .led       (led)
    );

    always #20 clk = ~clk;

    // ==================================================
    // helpers
    // ==================================================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    // one uart bit held for a full bit period
    task automatic send_bit(input logic b);
        @(posedge clk);
        uart_line <= b;
        repeat (`RBX_CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    // 8N1 frame with lsb first
    task automatic send_byte(input logic [7:0] data);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_bit(data[i]);
        end
        send_bit(1'b1);
    endtask

    task automatic send_entry(input logic en, input logic [4:0] addr,
                              input logic [31:0] value, input logic last);
        send_byte({last, 6'b000000, en});
        send_byte({3'b000, addr});
        send_byte(value[7:0]);
        send_byte(value[15:8]);
        send_byte(value[23:16]);
        send_byte(value[31:24]);
        // x0 stays zero and disabled entries write nothing
        if (en && addr != 5'd0) begin
            ref_regs[addr] = value;
        end
    endtask

    // playback has to start first since an old done may still be showing
    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (led[1] !== 1'b0 && cycles < BUSY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (led[1] !== 1'b0) begin
            timeout_count++;
            $display("TIMEOUT at time %0t: playback never started after the script",
                     $time);
        end else begin
            cycles = 0;
            while (led[2] !== 1'b0 && cycles < DONE_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (led[2] !== 1'b0) begin
                timeout_count++;
                $display("TIMEOUT at time %0t: playback did not finish", $time);
            end
        end
    endtask

    // both ports walk the bank in opposite directions
    task automatic check_all_regs();
        for (int i = 0; i < `RBX_NREGS; i++) begin
            @(posedge clk);
            rd_addr1 <= 5'(i);
            rd_addr2 <= 5'(`RBX_NREGS - 1 - i);
            @(negedge clk);
            check_value($sformatf("rd_value1 (x%0d)", i), ref_regs[i], rd_value1);
            check_value($sformatf("rd_value2 (x%0d)", `RBX_NREGS - 1 - i),
                        ref_regs[`RBX_NREGS - 1 - i], rd_value2);
        end
    endtask

    // ==================================================
    // tests
    // ==================================================
    task automatic test_reset();
        @(negedge clk);
        check_value("led", 32'h0000_003f, 32'(led));
        check_all_regs();
    endtask

    task automatic test_distinct_writes();
        send_entry(1'b1, 5'd1, 32'h1111_0001, 1'b0);
        send_entry(1'b1, 5'd2, 32'h2222_0002, 1'b0);
        send_entry(1'b1, 5'd7, 32'h7777_0007, 1'b0);
        send_entry(1'b1, 5'd15, 32'hf0f0_000f, 1'b0);
        send_entry(1'b1, 5'd31, 32'h8000_001f, 1'b1);
        wait_done();
        check_all_regs();
    endtask

    task automatic test_x0_write();
        send_entry(1'b1, 5'd3, 32'h0303_0303, 1'b0);
        send_entry(1'b1, 5'd0, 32'hdead_beef, 1'b0);
        send_entry(1'b1, 5'd4, 32'h0404_0404, 1'b1);
        wait_done();
        check_all_regs();
    endtask

    // disabled entries and repeated addresses
    task automatic test_disable_and_overwrite();
        // port 2 watches a disabled target during playback
        @(posedge clk);
        rd_addr2 <= 5'd5;
        send_entry(1'b0, 5'd5, 32'h5555_5555, 1'b0);
        send_entry(1'b1, 5'd6, 32'h6666_000a, 1'b0);
        send_entry(1'b1, 5'd6, 32'h6666_000b, 1'b0);
        send_entry(1'b0, 5'd6, 32'h6666_000c, 1'b0);
        send_entry(1'b0, 5'd1, 32'hbad0_0001, 1'b0);
        send_entry(1'b1, 5'd8, 32'h0808_0808, 1'b0);
        send_entry(1'b1, 5'd6, 32'h6666_000e, 1'b1);
        wait_done();
        check_all_regs();
    endtask

    // 31 random entries plus the end marker fill the script memory
    task automatic test_full_script();
        logic [31:0] r;
        logic [31:0] value;
        for (int i = 0; i < `RBX_SCRIPT_DEPTH; i++) begin
            r = $urandom;
            value = $urandom;
            send_entry(r[0], r[5:1], value, i == `RBX_SCRIPT_DEPTH - 1);
        end
        wait_done();
        check_all_regs();
    endtask

    task automatic test_x2_leds();
        logic [31:0] x2_value;
        logic [2:0]  exp_led;
        x2_value = 32'h0000_0005;
        send_entry(1'b1, 5'd9, 32'h0909_0909, 1'b0);
        send_entry(1'b1, 5'd2, x2_value, 1'b1);
        wait_done();
        exp_led = ~x2_value[2:0];
        @(negedge clk);
        check_value("led[5:3]", 32'(exp_led), 32'(led[5:3]));
        check_value("led[1]", 32'h1, 32'(led[1]));
        check_value("led[2]", 32'h0, 32'(led[2]));
        // write LED lit for one step after the last write
        check_value("led[0]", 32'h0, 32'(led[0]));
        repeat (`RBX_STEP_DIV) @(negedge clk);
        check_value("led[0]", 32'h1, 32'(led[0]));
        check_all_regs();
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        uart_line     = 1'b1;
        rd_addr1      = '0;
        rd_addr2      = '0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        for (int i = 0; i < `RBX_NREGS; i++) begin
            ref_regs[i] = '0;
        end
        void'($urandom(32'hf486_f9b0));

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        test_reset();
        test_distinct_writes();
        test_x0_write();
        test_disable_and_overwrite();
        test_full_script();
        test_x2_leds();

        $display("checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- source/rbx_consts.svh
`ifndef RBX_CONSTS_SVH
`define RBX_CONSTS_SVH

// ==================================================
// register bank geometry
// ==================================================
`define RBX_XLEN          32
`define RBX_RADDR_W       5
`define RBX_NREGS         32

// ==================================================
// script storage and timing
// ==================================================
`define RBX_SCRIPT_DEPTH  32
// short bit period keeps simulation fast
`define RBX_CLKS_PER_BIT  8
`define RBX_STEP_DIV      4

`endif

//--- source/rbx_pkg.sv
`include "rbx_consts.svh"

package rbx_pkg;

    // one register bank write, also the stored form of a script entry
    typedef struct packed {
        logic                    en;
        logic [`RBX_RADDR_W-1:0] addr;
        logic [`RBX_XLEN-1:0]    value;
    } rb_write_t;

    // received uart byte, valid is a single-cycle strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

    // position of the next byte within a six-byte entry
    typedef enum logic [2:0] {
        CMD,
        ADDR,
        B0,
        B1,
        B2,
        B3
    } loader_state_e;

endpackage

//--- source/rbx_top.sv
`timescale 1ns/10ps
`include "rbx_consts.svh"

module rbx_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    uart_rx,
    input  logic [`RBX_RADDR_W-1:0] rd_addr1,
    input  logic [`RBX_RADDR_W-1:0] rd_addr2,
    output logic [`RBX_XLEN-1:0]    rd_value1,
    output logic [`RBX_XLEN-1:0]    rd_value2,
    output logic [5:0]              led
);
    import rbx_pkg::*;

    rx_byte_t   rx_byte;
    rb_write_t  rd_entry;
    rb_write_t  wr;
    logic [4:0] rd_index;
    logic       start;
    logic [5:0] count;
    logic       busy;
    logic       done;
    logic       step_led;
    logic [2:0] x2_low;

    uart_rx u_uart_rx (
        .clk     (clk),
        .arst_n  (arst_n),
        .rx      (uart_rx),
        .rx_byte (rx_byte)
    );

    script_loader u_loader (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_byte  (rx_byte),
        .busy     (busy),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .start    (start),
        .count    (count)
    );

    script_player u_player (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .count    (count),
        .rd_entry (rd_entry),
        .rd_index (rd_index),
        .wr       (wr),
        .busy     (busy),
        .done     (done),
        .step_led (step_led)
    );

    register_bank u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (wr),
        .rd_addr1  (rd_addr1),
        .rd_addr2  (rd_addr2),
        .rd_value1 (rd_value1),
        .rd_value2 (rd_value2),
        .x2_low    (x2_low)
    );

    // LEDs light on a low level
    assign led[0]   = ~step_led;
    assign led[1]   = ~busy;
    assign led[2]   = ~done;
    assign led[5:3] = ~x2_low;

endmodule

//--- source/register_bank.sv
`timescale 1ns/10ps
`include "rbx_consts.svh"

module register_bank (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rbx_pkg::rb_write_t      wr,
    input  logic [`RBX_RADDR_W-1:0] rd_addr1,
    input  logic [`RBX_RADDR_W-1:0] rd_addr2,
    output logic [`RBX_XLEN-1:0]    rd_value1,
    output logic [`RBX_XLEN-1:0]    rd_value2,
    output logic [2:0]              x2_low
);
    logic [`RBX_XLEN-1:0] regs [`RBX_NREGS];

    // ==================================================
    // write port
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RBX_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.addr != '0) begin
            // x0 is hardwired, writes to it fall away
            regs[wr.addr] <= wr.value;
        end
    end

    // ==================================================
    // read ports
    // ==================================================
    assign rd_value1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_value2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

    // board LED view of x2
    assign x2_low = regs[2][2:0];

endmodule

//--- source/script_loader.sv
`timescale 1ns/10ps
`include "rbx_consts.svh"

module script_loader (
    input  logic               clk,
    input  logic               arst_n,
    input  rbx_pkg::rx_byte_t  rx_byte,
    input  logic               busy,
    input  logic [4:0]         rd_index,
    output rbx_pkg::rb_write_t rd_entry,
    output logic               start,
    output logic [5:0]         count
);
    import rbx_pkg::*;

    localparam logic [4:0] LAST_IDX = 5'(`RBX_SCRIPT_DEPTH - 1);

    rb_write_t     mem [`RBX_SCRIPT_DEPTH];
    loader_state_e state;
    logic [4:0]    wr_idx;
    logic          end_flag;
    logic          accept;
    rb_write_t     asm_q;
    rb_write_t     new_entry;

    // nothing is taken in while the player runs
    assign accept = rx_byte.valid && !busy;

    // entry as it stands once the top value byte lands
    always_comb begin
        new_entry = asm_q;
        new_entry.value[31:24] = rx_byte.data;
    end

    // ==================================================
    // byte position FSM and write index
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= CMD;
            wr_idx   <= '0;
            end_flag <= 1'b0;
            start    <= 1'b0;
            count    <= '0;
        end else begin
            start <= 1'b0;
            if (accept) begin
                case (state)
                    CMD: begin
                        end_flag <= rx_byte.data[7];
                        state    <= ADDR;
                    end
                    ADDR: state <= B0;
                    B0:   state <= B1;
                    B1:   state <= B2;
                    B2:   state <= B3;
                    B3: begin
                        state <= CMD;
                        // a full memory closes the script as well
                        if (end_flag || wr_idx == LAST_IDX) begin
                            start  <= 1'b1;
                            count  <= {1'b0, wr_idx} + 6'd1;
                            wr_idx <= '0;
                        end else begin
                            wr_idx <= wr_idx + 5'd1;
                        end
                    end
                    default: state <= CMD;
                endcase
            end
        end
    end

    // entry assembly, lsb value byte first
    always_ff @(posedge clk) begin
        if (accept) begin
            case (state)
                CMD:  asm_q.en            <= rx_byte.data[0];
                ADDR: asm_q.addr          <= rx_byte.data[4:0];
                B0:   asm_q.value[7:0]    <= rx_byte.data;
                B1:   asm_q.value[15:8]   <= rx_byte.data;
                B2:   asm_q.value[23:16]  <= rx_byte.data;
                default: asm_q <= asm_q;
            endcase
        end
    end

    // script memory
    always_ff @(posedge clk) begin
        if (accept && state == B3) begin
            mem[wr_idx] <= new_entry;
        end
    end

    assign rd_entry = mem[rd_index];

endmodule

//--- source/script_player.sv
`timescale 1ns/10ps
`include "rbx_consts.svh"

module script_player (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  logic [5:0]         count,
    input  rbx_pkg::rb_write_t rd_entry,
    output logic [4:0]         rd_index,
    output rbx_pkg::rb_write_t wr,
    output logic               busy,
    output logic               done,
    output logic               step_led
);
    localparam int DIV_W = $clog2(`RBX_STEP_DIV) + 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`RBX_STEP_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [4:0]       idx;
    logic             last_entry;

    assign tick       = (div_cnt == DIV_LAST);
    assign last_entry = ({1'b0, idx} == count - 6'd1);
    assign rd_index   = idx;

    // step divider, realigned on start so entry k lands on tick k
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (start || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    // ==================================================
    // playback
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_led <= 1'b0;
            idx      <= '0;
            wr       <= '0;
        end else begin
            // write strobe lasts a single clock
            wr.en <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
                idx  <= '0;
            end else if (tick) begin
                step_led <= 1'b0;
                if (busy) begin
                    wr       <= rd_entry;
                    step_led <= rd_entry.en;
                    if (last_entry) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        idx <= idx + 5'd1;
                    end
                end
            end
        end
    end

endmodule

//--- source/uart_rx.sv
`timescale 1ns/10ps
`include "rbx_consts.svh"

module uart_rx (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              rx,
    output rbx_pkg::rx_byte_t rx_byte
);
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_e;

    localparam int CNT_W = $clog2(`RBX_CLKS_PER_BIT) + 1;
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`RBX_CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`RBX_CLKS_PER_BIT - 1);

    logic [1:0]       rx_sync;
    logic             rx_s;
    rx_state_e        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    assign rx_s = rx_sync[1];

    // ==================================================
    // frame FSM, samples at mid-bit
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            shift   <= '0;
            rx_byte <= '0;
        end else begin
            rx_byte.valid <= 1'b0;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_s) begin
                        state <= START;
                    end
                end
                START: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // glitch shorter than half a bit goes back to idle
                        state   <= rx_s ? IDLE : DATA;
                    end else begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
                DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        shift   <= {rx_s, shift[7:1]};
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
                STOP: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        state   <= IDLE;
                        // framing error drops the byte
                        if (rx_s) begin
                            rx_byte.valid <= 1'b1;
                            rx_byte.data  <= shift;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + CNT_W'(1);
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- vlog.f
+incdir+source
source/rbx_pkg.sv
source/uart_rx.sv
source/script_loader.sv
source/script_player.sv
source/register_bank.sv
source/rbx_top.sv
dv/rbx_assert.sv
dv/rbx_tb.sv
